/* Makefile */
# Verilator build and run for the return address stack testbench

VERILATOR ?= verilator
TOP       ?= tb_bpu_ras
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and grep the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+logic
logic/bpu_pkg.sv
logic/call_ret_decode.sv
logic/ras.sv
logic/target_select.sv
logic/bpu_ras_top.sv
verification/clk_rst_gen.sv
verification/tb_bpu_ras.sv

/* logic/bpu_consts.svh */
// Return address stack constants
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// ------------------------------------------------------------
// Stack geometry
// ------------------------------------------------------------
// log2 of the stack depth, 8 entries by default
`define RAS_STACK_WIDTH 3
// Full stack policy: "ON" drops the push, "OFF" wraps over the oldest
`define RAS_WRITE_GUARD "OFF"

// ------------------------------------------------------------
// RISC-V encodings
// ------------------------------------------------------------
// Link registers x1 (ra) and x5 (t0)
`define RV_REG_RA 5'd1
`define RV_REG_T0 5'd5
// Jump opcodes
`define RV_OP_JAL  7'b1101111
`define RV_OP_JALR 7'b1100111

`endif

/* logic/bpu_pkg.sv */
// Return address stack types
package bpu_pkg;

    // Fetched instruction slot, pc is a word address
    typedef struct packed {
        logic        valid;
        logic [29:0] pc;
        logic [31:0] instr;
    } fetch_slot_t;

    // Request from decode into the stack
    typedef struct packed {
        logic        push;
        logic        pop;
        logic [29:0] ret_addr;
    } ras_req_t;

    // Stack answer to a pop, one cycle later
    typedef struct packed {
        logic        valid;
        // Low when the pop found nothing
        logic        hit;
        logic [29:0] target;
    } ras_rsp_t;

    // Prediction towards fetch
    typedef struct packed {
        logic        valid;
        logic [29:0] target;
    } ras_pred_t;

endpackage : bpu_pkg

/* logic/bpu_ras_top.sv */
// Return address predictor top
`timescale 1ns/100ps

module bpu_ras_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bpu_pkg::fetch_slot_t fetch_i,
    output bpu_pkg::ras_pred_t   pred_o,
    output logic                 full_o,
    output logic                 empty_o,
    output logic [15:0]          underflow_cnt_o
);

    // Decode to stack
    bpu_pkg::ras_req_t ras_req;
    // Stack to output stage
    bpu_pkg::ras_rsp_t ras_rsp;

    // ------------------------------------------------------------
    // Input side, combinational
    // ------------------------------------------------------------
    call_ret_decode u_call_ret_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetch_i (fetch_i),
        .req_o   (ras_req)
    );

    // Stack with default depth and guard
    ras u_ras (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (ras_req),
        .rsp_o   (ras_rsp),
        .full_o  (full_o),
        .empty_o (empty_o)
    );

    // ------------------------------------------------------------
    // Output side, second pipeline stage
    // ------------------------------------------------------------
    target_select u_target_select (
        .clk             (clk),
        .rst_n           (rst_n),
        .rsp_i           (ras_rsp),
        .pred_o          (pred_o),
        .underflow_cnt_o (underflow_cnt_o)
    );

endmodule : bpu_ras_top

/* logic/call_ret_decode.sv */
// Call and return decode
`timescale 1ns/100ps
`include "bpu_consts.svh"

module call_ret_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bpu_pkg::fetch_slot_t fetch_i,
    output bpu_pkg::ras_req_t    req_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       is_jal;
    logic       is_jalr;
    logic       rd_link;
    logic       rs1_link;

    // x1 and x5 both count as link registers
    function automatic logic is_link(input logic [4:0] r);
        return (r == `RV_REG_RA) || (r == `RV_REG_T0);
    endfunction

    // ------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------
    assign opcode = fetch_i.instr[6:0];
    assign rd     = fetch_i.instr[11:7];
    assign funct3 = fetch_i.instr[14:12];
    assign rs1    = fetch_i.instr[19:15];

    assign is_jal   = (opcode == `RV_OP_JAL);
    // JALR is only defined with funct3 zero
    assign is_jalr  = (opcode == `RV_OP_JALR) && (funct3 == 3'b000);
    assign rd_link  = is_link(rd);
    assign rs1_link = is_link(rs1);

    // ------------------------------------------------------------
    // Call / return classification
    // ------------------------------------------------------------
    // Any jump that writes a link register is a call
    assign req_o.push = fetch_i.valid & (is_jal | is_jalr) & rd_link;

    // Return through a link register
    // Both links and different registers means coroutine, push and pop
    // Same link register on both sides stays a plain call
    assign req_o.pop = fetch_i.valid & is_jalr & rs1_link & (~rd_link | (rd != rs1));

    // Next sequential word
    assign req_o.ret_addr = fetch_i.pc + 30'd1;

    // Idle slots never touch the stack
    a_idle_quiet : assert property (
        @(posedge clk) disable iff (!rst_n)
        !fetch_i.valid |-> (!req_o.push && !req_o.pop)
    );

endmodule : call_ret_decode

/* logic/ras.sv */
// Return address stack
`timescale 1ns/100ps
`include "bpu_consts.svh"

module ras #(
    parameter int STACK_WIDTH = `RAS_STACK_WIDTH,
    parameter     WRITE_GUARD = `RAS_WRITE_GUARD
) (
    input  logic                clk,
    input  logic                rst_n,
    input  bpu_pkg::ras_req_t   req_i,
    output bpu_pkg::ras_rsp_t   rsp_o,
    output logic                full_o,
    output logic                empty_o
);

    localparam int STACK_DEPTH  = 1 << STACK_WIDTH;
    // Guard off lets a full stack wrap over its oldest entry
    localparam bit WRAP_ON_FULL = (WRITE_GUARD == "OFF");

    logic [29:0]            stack_mem [STACK_DEPTH];
    // Points at the next free slot
    logic [STACK_WIDTH-1:0] sp;
    logic [STACK_WIDTH:0]   count;
    logic                   full;
    logic                   empty;
    logic                   push_only;
    logic                   pop_only;
    logic                   push_pop;
    logic                   we;
    logic [STACK_WIDTH-1:0] top_idx;
    logic [29:0]            top_data;
    logic [29:0]            rsp_target_d;
    logic                   rsp_valid_q;
    logic                   rsp_hit_q;
    logic [29:0]            rsp_target_q;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------
    assign push_only = req_i.push & ~req_i.pop;
    assign pop_only  = req_i.pop & ~req_i.push;
    // Coroutine, pointer stays where it is
    assign push_pop  = req_i.push & req_i.pop;

    // Count never exceeds depth, so the MSB alone marks full
    assign full  = count[STACK_WIDTH];
    assign empty = (count == '0);

    // Dropped when full unless wrapping is allowed
    assign we = push_only & (~full | WRAP_ON_FULL);

    // ------------------------------------------------------------
    // Pointer and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sp <= '0;
        end else if (we) begin
            // Wraps naturally past the last entry
            sp <= sp + 1'b1;
        end else if (pop_only && !empty) begin
            sp <= sp - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (push_only && !full) begin
            count <= count + 1'b1;
        end else if (pop_only && !empty) begin
            count <= count - 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (we) begin
            stack_mem[sp] <= req_i.ret_addr;
        end
    end

    // Top of stack sits just below the pointer
    assign top_idx  = sp - 1'b1;
    assign top_data = stack_mem[top_idx];

    // Forward on coroutine, zero on underflow
    assign rsp_target_d = push_pop ? req_i.ret_addr :
                          !empty   ? top_data       : 30'd0;

    // ------------------------------------------------------------
    // Registered response
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            rsp_hit_q   <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.pop;
            rsp_hit_q   <= req_i.pop & (req_i.push | ~empty);
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.pop) begin
            rsp_target_q <= rsp_target_d;
        end
    end

    assign rsp_o.valid  = rsp_valid_q;
    assign rsp_o.hit    = rsp_hit_q;
    assign rsp_o.target = rsp_target_q;
    assign full_o       = full;
    assign empty_o      = empty;

    // Occupancy bounded by depth
    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= STACK_DEPTH
    );

    a_flags_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(full_o && empty_o)
    );

endmodule : ras

/* logic/target_select.sv */
// Prediction output stage
`timescale 1ns/100ps

module target_select (
    input  logic               clk,
    input  logic               rst_n,
    input  bpu_pkg::ras_rsp_t  rsp_i,
    output bpu_pkg::ras_pred_t pred_o,
    output logic [15:0]        underflow_cnt_o
);

    logic        hit;
    logic        underflow;
    logic        pred_valid_q;
    logic [29:0] pred_target_q;
    logic [15:0] underflow_cnt_q;

    assign hit       = rsp_i.valid & rsp_i.hit;
    // Return that found nothing on the stack
    assign underflow = rsp_i.valid & ~rsp_i.hit;

    // ------------------------------------------------------------
    // Prediction register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid_q <= 1'b0;
        end else begin
            pred_valid_q <= hit;
        end
    end

    // Target held until the next hit
    always_ff @(posedge clk) begin
        if (hit) begin
            pred_target_q <= rsp_i.target;
        end
    end

    // ------------------------------------------------------------
    // Underflow counter, saturating
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            underflow_cnt_q <= '0;
        end else if (underflow && !(&underflow_cnt_q)) begin
            underflow_cnt_q <= underflow_cnt_q + 16'd1;
        end
    end

    assign pred_o.valid    = pred_valid_q;
    assign pred_o.target   = pred_target_q;
    assign underflow_cnt_o = underflow_cnt_q;

    // Hit only arrives on a valid response
    a_hit_needs_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_i.hit |-> rsp_i.valid
    );

endmodule : target_select

/* verification/clk_rst_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps

module clk_rst_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Released just after the last reset edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule : clk_rst_gen

/* verification/tb_bpu_ras.sv */
// Return address stack testbench
`timescale 1ns/100ps
`include "bpu_consts.svh"

module tb_bpu_ras;

    localparam int DEPTH = 1 << `RAS_STACK_WIDTH;
    localparam logic [2:0] K_IDLE  = 3'd0;
    localparam logic [2:0] K_CALL  = 3'd1;
    localparam logic [2:0] K_RET   = 3'd2;
    localparam logic [2:0] K_CORO  = 3'd3;
    localparam logic [2:0] K_OTHER = 3'd4;

    // One table row, flags are the state seen while the step is presented
    typedef struct packed {
        logic [2:0]  kind;
        logic [29:0] pc;
        logic        exp_valid;
        logic [29:0] exp_target;
        logic        exp_full;
        logic        exp_empty;
        logic [15:0] exp_ucnt;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    bpu_pkg::fetch_slot_t fetch;
    bpu_pkg::ras_pred_t   pred;
    logic                 full;
    logic                 empty;
    logic [15:0]          ucnt;
    step_t                steps [$];
    string                names [$];
    // Reference stack, newest at the back
    logic [29:0]          model_stack [$];
    int                   model_ucnt = 0;
    int                   cycle_cnt = 0;
    int                   timeout_limit = 1000;

    clk_rst_gen u_clk_rst_gen (.clk_o(clk), .rst_n_o(rst_n));

    bpu_ras_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_i         (fetch),
        .pred_o          (pred),
        .full_o          (full),
        .empty_o         (empty),
        .underflow_cnt_o (ucnt)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [29:0] rand_pc();
        return 30'($urandom());
    endfunction

    // Idle slots carry a call, so valid gating gets exercised
    function automatic logic [31:0] encode_instr(input logic [2:0] kind);
        case (kind)
            K_RET:   return {12'd0, `RV_REG_RA, 3'b000, 5'd0, `RV_OP_JALR};
            K_CORO:  return {12'd0, `RV_REG_RA, 3'b000, `RV_REG_T0, `RV_OP_JALR};
            // ADDI ra, ra, 4
            K_OTHER: return {12'd4, `RV_REG_RA, 3'b000, `RV_REG_RA, 7'b0010011};
            default: return {20'd0, `RV_REG_RA, `RV_OP_JAL};
        endcase
    endfunction

    // Appends a row and advances the reference stack
    task automatic add_step(input string name, input logic [2:0] kind, input logic [29:0] pc);
        step_t       s;
        logic [29:0] link;
        link        = pc + 30'd1;
        s           = '0;
        s.kind      = kind;
        s.pc        = pc;
        s.exp_full  = (model_stack.size() == DEPTH);
        s.exp_empty = (model_stack.size() == 0);
        if (kind == K_CALL) begin
            // Full stack: wrap loses the oldest, guard drops the push
            if (model_stack.size() < DEPTH) begin
                model_stack.push_back(link);
            end else if (`RAS_WRITE_GUARD == "OFF") begin
                void'(model_stack.pop_front());
                model_stack.push_back(link);
            end
        end else if (kind == K_RET) begin
            if (model_stack.size() > 0) begin
                s.exp_valid  = 1'b1;
                s.exp_target = model_stack.pop_back();
            end else begin
                model_ucnt++;
            end
        end else if (kind == K_CORO) begin
            s.exp_valid  = 1'b1;
            s.exp_target = link;
        end
        s.exp_ucnt = 16'(model_ucnt);
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        add_step("reset_idle", K_IDLE, rand_pc());
        add_step("reset_idle", K_IDLE, rand_pc());
        repeat (3) add_step("nest_call", K_CALL, rand_pc());
        repeat (3) add_step("nest_ret", K_RET, rand_pc());
        add_step("coro_call", K_CALL, rand_pc());
        add_step("coro_jump", K_CORO, rand_pc());
        add_step("coro_ret", K_RET, rand_pc());
        // Nine into eight entries
        repeat (DEPTH + 1) add_step("ovf_call", K_CALL, rand_pc());
        repeat (DEPTH) add_step("ovf_ret", K_RET, rand_pc());
        repeat (2) add_step("udf_ret", K_RET, rand_pc());
        add_step("nonbranch", K_OTHER, rand_pc());
        add_step("idle", K_IDLE, rand_pc());
        repeat (2) add_step("b2b_call", K_CALL, rand_pc());
        repeat (2) add_step("b2b_ret", K_RET, rand_pc());
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout: test did not finish within %0d cycles", timeout_limit);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        step_t row;
        fetch         = '0;
        void'($urandom(39331));
        build_table();
        timeout_limit = steps.size() + 50;
        wait (rst_n === 1'b1);
        // Two extra slots drain the pipeline
        for (int idx = 0; idx < steps.size() + 2; idx++) begin
            @(posedge clk);
            #1;
            if (idx >= 2) begin
                row = steps[idx-2];
                check_val({names[idx-2], " pred_valid"}, row.exp_valid, pred.valid);
                if (row.exp_valid) begin
                    check_val({names[idx-2], " target"}, row.exp_target, pred.target);
                end
                check_val({names[idx-2], " underflow_cnt"}, row.exp_ucnt, ucnt);
            end else begin
                check_val("reset pred_valid", 0, pred.valid);
                check_val("reset underflow_cnt", 0, ucnt);
            end
            if (idx < steps.size()) begin
                row = steps[idx];
                check_val({names[idx], " full"}, row.exp_full, full);
                check_val({names[idx], " empty"}, row.exp_empty, empty);
                fetch.valid = (row.kind != K_IDLE);
                fetch.pc    = row.pc;
                fetch.instr = encode_instr(row.kind);
            end else begin
                fetch = '0;
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_bpu_ras
